/* digit_scanner.sv */
//------------------------------
// Digit scanner.
// Steps through the digits and picks each digit's nibble and enable.
//------------------------------
module digit_scanner
	import seg_pkg::*;
(
	input  logic          sys_clk,		// System clock.
	input  logic          sys_rst_n,	// Synchronous reset, active low.
	input  logic          scan_tick,	// Digit step enable.
	input  display_word_t frame_val,	// Word of the running frame.
	input  digit_mask_t   frame_mask,	// Mask of the running frame.
	output logic          frame_wrap,	// High on the tick that ends the frame.
	output nibble_t       digit_nibble,	// Registered nibble of the scanned digit.
	output logic          digit_on,		// Registered enable of the scanned digit.
	output digit_idx_t    digit_idx		// Registered index of the scanned digit.
);

	digit_idx_t scan_idx;	// Digit being scanned.
	digit_idx_t nib_pos;	// Nibble position in the word, counted from the bottom.
	nibble_t    cur_nibble;	// Nibble picked for the current index.

	// Scan index. It moves on every tick and wraps from the last digit to 0.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			scan_idx <= '0;				// Frame starts at digit 0.
		end else if (scan_tick) begin
			if (scan_idx == last_digit) begin
				scan_idx <= '0;			// Next frame.
			end else begin
				scan_idx <= scan_idx + 1'b1;	// Next digit.
			end
		end
	end

	// The wrap goes back to the frame buffer in the same cycle.
	assign frame_wrap = scan_tick && (scan_idx == last_digit);

	// Digit 0 holds the top nibble, so the position counts down as the index goes up.
	assign nib_pos    = last_digit - scan_idx;
	assign cur_nibble = frame_val[{nib_pos, 2'b00} +: nibble_w];

	// Control side of the pipeline register.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			digit_on  <= 1'b0;			// Nothing lit after reset.
			digit_idx <= '0;			// Matches the reset scan index.
		end else begin
			digit_on  <= frame_mask[scan_idx];	// Enable of the digit in view.
			digit_idx <= scan_idx;			// Index travels with its data.
		end
	end

	// Payload side of the pipeline register.
	always_ff @(posedge sys_clk) begin
		digit_nibble <= cur_nibble;	// One cycle behind the index.
	end

endmodule

/* frame_buffer.sv */
//------------------------------
// Frame buffer.
// Holds a loaded word and mask in a shadow and commits them at the frame wrap.
//------------------------------
module frame_buffer
	import seg_pkg::*;
(
	input  logic          sys_clk,		// System clock.
	input  logic          sys_rst_n,	// Synchronous reset, active low.
	input  display_word_t seg_val,		// Word to show, digit 0 in the top nibble.
	input  digit_mask_t   seg_sel,		// Digit enable mask.
	input  logic          val_load,		// Single-cycle load strobe.
	input  logic          frame_wrap,	// Last digit's tick, end of a scan frame.
	output display_word_t frame_val,	// Word shown in the current frame.
	output digit_mask_t   frame_mask	// Mask used in the current frame.
);

	display_word_t shadow_val;	// Last loaded word, waiting for the wrap.
	digit_mask_t   shadow_mask;	// Last loaded mask, waiting for the wrap.
	logic          pending;		// A load is held in the shadow.
	display_word_t active_val;	// Word of the running frame.
	digit_mask_t   active_mask;	// Mask of the running frame.
	logic          commit;		// The shadow moves to the active frame on this edge.

	// Commit only at a wrap and only when something new was loaded.
	assign commit = frame_wrap && pending;

	// The shadow takes every load, a later load simply replaces an earlier one.
	always_ff @(posedge sys_clk) begin
		if (val_load) begin
			shadow_val  <= seg_val;		// Sample the word on the strobe.
			shadow_mask <= seg_sel;		// Sample the mask on the same edge.
		end
	end

	// Pending flag. A load on the commit edge wins and keeps the flag set.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pending <= 1'b0;		// Nothing held after reset.
		end else if (val_load) begin
			pending <= 1'b1;		// New value waits for the next wrap.
		end else if (commit) begin
			pending <= 1'b0;		// Shadow has been taken.
		end
	end

	// Active frame. It only changes at a wrap, so no frame mixes two values.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			active_val  <= '0;		// Blank word after reset.
			active_mask <= '0;		// All digits disabled until a commit.
		end else if (commit) begin
			active_val  <= shadow_val;	// Take the held word.
			active_mask <= shadow_mask;	// Take the held mask.
		end
	end

	assign frame_val  = active_val;		// Feed the scanner.
	assign frame_mask = active_mask;	// Feed the scanner.

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the seven-segment display testbench with Verilator and runs it.
# Exits non-zero when the build, the run or the checks fail.

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
top=tb_seg_display

verilator --binary --timing -f tb.f --top-module "$top" -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if [ ! -s "$log" ]; then
	echo "simulation log is empty"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
	echo "simulation reported failures, see $log"
	exit 1
fi

exit 0

/* scan_tick_gen.sv */
//------------------------------
// Scan tick generator.
// Turns sys_clk into a one-cycle enable at the digit scan rate.
//------------------------------
module scan_tick_gen #(
	parameter int unsigned clk_freq_hz   = 50_000_000,	// System clock frequency in Hz.
	parameter int unsigned digit_rate_hz = 1000		// Digit step rate in Hz.
) (
	input  logic sys_clk,		// System clock.
	input  logic sys_rst_n,		// Synchronous reset, active low.
	output logic scan_tick		// One-cycle pulse per digit step.
);

	// Clock cycles per digit step.
	localparam int unsigned div_count = clk_freq_hz / digit_rate_hz;

	// Counter width, kept at one bit for a divider of one.
	localparam int cnt_w = (div_count > 1) ? $clog2(div_count) : 1;

	// Terminal count of the divider.
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(div_count - 1);

	logic [cnt_w-1:0] tick_cnt;	// Cycles elapsed in the current digit slot.

	// The counter runs from zero to the terminal count and starts over.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			tick_cnt <= '0;				// Start of a slot after reset.
		end else if (tick_cnt == cnt_last) begin
			tick_cnt <= '0;				// Slot done, begin the next one.
		end else begin
			tick_cnt <= tick_cnt + 1'b1;	// Count one more cycle.
		end
	end

	// The tick marks the last cycle of each slot, so the first one falls in the
	// divider-th cycle after reset and then repeats every divider cycles.
	assign scan_tick = (tick_cnt == cnt_last);

endmodule

/* seg_checker.sv */
//------------------------------
// Display output checker.
// Cycle model of the scan driver, compares both outputs every cycle.
//------------------------------
module seg_checker
	import seg_pkg::*;
#(
	parameter int unsigned clk_freq_hz   = 1000,	// System clock frequency in Hz.
	parameter int unsigned digit_rate_hz = 250	// Digit step rate in Hz.
) (
	input  logic          sys_clk,
	input  logic          sys_rst_n,
	input  display_word_t seg_val,
	input  digit_mask_t   seg_sel,
	input  logic          val_load,
	input  seg_pattern_t  seg_val_out,
	input  digit_mask_t   seg_sel_out,
	input  int            test_num,
	input  logic          test_run,
	input  logic          test_timeout,
	input  logic          all_done,
	output int            pass_count,
	output int            fail_count,
	output int            timeout_count,
	output logic          stalled,
	output logic          report_done
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned div_count  = clk_freq_hz / digit_rate_hz;
	localparam int          idle_limit = 200;	// Cycles allowed between two phases.
	// Common anode patterns, entry 0 in the low byte.
	localparam logic [127:0] hex_rom = {8'h8E, 8'h84, 8'hA1, 8'hA7, 8'h83, 8'h88, 8'h90, 8'h80,
		8'hF8, 8'h82, 8'h92, 8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0};

	int unsigned   m_cnt;
	digit_idx_t    m_idx;
	display_word_t m_shadow_val, m_active_val;
	digit_mask_t   m_shadow_mask, m_active_mask;
	logic          m_pending;
	logic          s1_on;		// First pipeline stage.
	digit_idx_t    s1_idx;
	nibble_t       s1_nib;
	seg_pattern_t  exp_seg = '1;	// Second stage, the expected ports.
	digit_mask_t   exp_sel = '1;
	logic          model_valid = 1'b0;
	logic          m_tick, m_wrap, mismatch;
	logic          run_q = 1'b0;
	logic          stray_seen = 1'b0;
	int            idle_cnt = 0;
	int            cur_errors = 0;
	int            cur_cycles = 0;
	seg_pattern_t  first_exp_seg, first_act_seg;
	digit_mask_t   first_exp_sel, first_act_sel;

	initial begin
		pass_count    = 0;
		fail_count    = 0;
		timeout_count = 0;
		stalled       = 1'b0;
		report_done   = 1'b0;
	end

	function automatic string test_name(input int n);
		case (n)
			0:       test_name = "reset_blank";
			1:       test_name = "hex_decode";
			2:       test_name = "scan_order";
			3:       test_name = "enable_mask";
			4:       test_name = "frame_update";
			5:       test_name = "random_run";
			default: test_name = "unknown";
		endcase
	endfunction

	// Every select line high except the one of the given digit.
	function automatic digit_mask_t select_pattern(input digit_idx_t idx);
		select_pattern      = '1;
		select_pattern[idx] = 1'b0;
	endfunction

	assign m_tick = (m_cnt == div_count - 1);	// Last cycle of a digit slot.
	assign m_wrap = m_tick && (int'(m_idx) == digit_count - 1);

	// Reference model, one update per rising edge.
	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			model_valid   <= 1'b1;	// Compare once reset has been seen.
			m_cnt         <= 0;
			m_idx         <= '0;
			m_pending     <= 1'b0;
			m_active_val  <= '0;
			m_active_mask <= '0;
			s1_on         <= 1'b0;
			s1_idx        <= '0;
			exp_seg       <= '1;
			exp_sel       <= '1;
		end else begin
			m_cnt <= m_tick ? 0 : m_cnt + 1;
			if (m_tick) m_idx <= m_wrap ? '0 : m_idx + 1'b1;
			if (val_load) begin
				m_shadow_val  <= seg_val;
				m_shadow_mask <= seg_sel;
			end
			if (val_load) m_pending <= 1'b1;	// A load on the wrap edge stays pending.
			else if (m_wrap && m_pending) m_pending <= 1'b0;
			if (m_wrap && m_pending) begin
				m_active_val  <= m_shadow_val;
				m_active_mask <= m_shadow_mask;
			end
			s1_on  <= m_active_mask[m_idx];
			s1_idx <= m_idx;
			s1_nib <= m_active_val[(digit_count - 1 - int'(m_idx)) * 4 +: 4];	// Digit 0 on top.
			exp_seg <= s1_on ? hex_rom[int'(s1_nib) * 8 +: 8] : '1;
			exp_sel <= s1_on ? select_pattern(s1_idx) : '1;
		end
	end

	task automatic report_test();
		if (test_timeout) begin
			$display("test %s timed out waiting for a frame wrap", test_name(test_num));
			timeout_count++;
		end else if (cur_errors != 0) begin
			$display("error %s expected seg=%h sel=%h actual seg=%h sel=%h, %0d bad cycles",
				test_name(test_num), first_exp_seg, first_exp_sel, first_act_seg,
				first_act_sel, cur_errors);
			fail_count++;
		end else begin
			$display("pass %s, %0d cycles checked", test_name(test_num), cur_cycles);
			pass_count++;
		end
	endtask

	// Outputs and phase flags are stable at the falling edge.
	always @(negedge sys_clk) begin
		mismatch = model_valid && (seg_val_out !== exp_seg || seg_sel_out !== exp_sel);
		if (test_run && !run_q) begin
			cur_errors = 0;
			cur_cycles = 0;
			idle_cnt   = 0;
		end
		if (test_run) begin
			cur_cycles++;
			if (mismatch && cur_errors == 0) begin
				first_exp_seg = exp_seg;	// Keep the first bad cycle for the report.
				first_exp_sel = exp_sel;
				first_act_seg = seg_val_out;
				first_act_sel = seg_sel_out;
			end
			if (mismatch) cur_errors++;
		end else if (mismatch && !stray_seen) begin
			$display("error between_tests expected seg=%h sel=%h actual seg=%h sel=%h",
				exp_seg, exp_sel, seg_val_out, seg_sel_out);
			stray_seen = 1'b1;
			fail_count++;
		end
		if (!test_run && run_q) report_test();
		if (!test_run && !all_done && !stalled) begin
			idle_cnt++;
			if (idle_cnt > idle_limit) begin
				$display("no test started within %0d cycles", idle_limit);
				stalled = 1'b1;
			end
		end
		if (all_done && !report_done) begin
			$display("tests passed %0d, failed %0d, timed out %0d",
				pass_count, fail_count, timeout_count);
			report_done = 1'b1;
		end
		run_q = test_run;
	end

endmodule

/* seg_display.sv */
//------------------------------
// Eight-digit seven-segment display driver.
// Scans a loaded hex word onto a multiplexed display with frame-synchronous updates.
//------------------------------
module seg_display
	import seg_pkg::*;
#(
	parameter int unsigned clk_freq_hz   = 50_000_000,	// System clock frequency in Hz.
	parameter int unsigned digit_rate_hz = 1000		// Digit step rate in Hz.
) (
	input  logic          sys_clk,		// System clock.
	input  logic          sys_rst_n,	// Synchronous reset, active low.
	input  display_word_t seg_val,		// Hex word, digit 0 in the top nibble.
	input  digit_mask_t   seg_sel,		// Digit enable mask.
	input  logic          val_load,		// Single-cycle load strobe.
	output seg_pattern_t  seg_val_out,	// Active-low segment pattern.
	output digit_mask_t   seg_sel_out	// Active-low one-hot digit select.
);

	logic          scan_tick;		// Digit step enable.
	logic          frame_wrap;		// End of a scan frame, back to the buffer.
	display_word_t frame_val;		// Word of the running frame.
	digit_mask_t   frame_mask;		// Mask of the running frame.
	nibble_t       digit_nibble;	// Nibble of the scanned digit.
	logic          digit_on;		// Enable of the scanned digit.
	digit_idx_t    digit_idx;		// Index of the scanned digit.

	// Scan rate divider.
	scan_tick_gen #(
		.clk_freq_hz   (clk_freq_hz),
		.digit_rate_hz (digit_rate_hz)
	) u_scan_tick_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scan_tick (scan_tick)
	);

	// Shadow and active frame registers.
	frame_buffer u_frame_buffer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.seg_val    (seg_val),
		.seg_sel    (seg_sel),
		.val_load   (val_load),
		.frame_wrap (frame_wrap),
		.frame_val  (frame_val),
		.frame_mask (frame_mask)
	);

	// Index stepping and nibble selection.
	digit_scanner u_digit_scanner (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.scan_tick    (scan_tick),
		.frame_val    (frame_val),
		.frame_mask   (frame_mask),
		.frame_wrap   (frame_wrap),
		.digit_nibble (digit_nibble),
		.digit_on     (digit_on),
		.digit_idx    (digit_idx)
	);

	// Hex decode and output registers.
	seg_encoder u_seg_encoder (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.digit_nibble (digit_nibble),
		.digit_on     (digit_on),
		.digit_idx    (digit_idx),
		.seg_val_out  (seg_val_out),
		.seg_sel_out  (seg_sel_out)
	);

endmodule

/* seg_encoder.sv */
//------------------------------
// Segment encoder.
// Decodes the hex nibble and drives the registered segment and select outputs.
//------------------------------
module seg_encoder
	import seg_pkg::*;
(
	input  logic         sys_clk,		// System clock.
	input  logic         sys_rst_n,		// Synchronous reset, active low.
	input  nibble_t      digit_nibble,	// Nibble of the scanned digit.
	input  logic         digit_on,		// Digit is enabled.
	input  digit_idx_t   digit_idx,		// Index of the scanned digit.
	output seg_pattern_t seg_val_out,	// Active-low segment pattern.
	output digit_mask_t  seg_sel_out	// Active-low one-hot digit select.
);

	seg_pattern_t hex_pattern;	// Table pattern for the nibble.
	digit_mask_t  one_hot_sel;	// Active-low select for the index.

	// Hex table for a common anode display, a low bit lights the segment.
	always_comb begin
		case (digit_nibble)
			4'h0:    hex_pattern = 8'hC0;
			4'h1:    hex_pattern = 8'hF9;
			4'h2:    hex_pattern = 8'hA4;
			4'h3:    hex_pattern = 8'hB0;
			4'h4:    hex_pattern = 8'h99;
			4'h5:    hex_pattern = 8'h92;
			4'h6:    hex_pattern = 8'h82;
			4'h7:    hex_pattern = 8'hF8;
			4'h8:    hex_pattern = 8'h80;
			4'h9:    hex_pattern = 8'h90;
			4'hA:    hex_pattern = 8'h88;
			4'hB:    hex_pattern = 8'h83;
			4'hC:    hex_pattern = 8'hA7;
			4'hD:    hex_pattern = 8'hA1;
			4'hE:    hex_pattern = 8'h84;
			default: hex_pattern = 8'h8E;	// Nibble F.
		endcase
	end

	// Only the scanned digit's select bit goes low.
	assign one_hot_sel = ~(digit_mask_t'(1) << digit_idx);

	// Output register. A disabled digit keeps both outputs dark.
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			seg_val_out <= seg_blank;		// All segments off.
			seg_sel_out <= sel_none;		// All digits off.
		end else if (digit_on) begin
			seg_val_out <= hex_pattern;		// Light the digit's pattern.
			seg_sel_out <= one_hot_sel;		// Drive its select.
		end else begin
			seg_val_out <= seg_blank;		// Disabled digit stays dark.
			seg_sel_out <= sel_none;		// And is not selected.
		end
	end

endmodule

/* seg_pkg.sv */
//------------------------------
// Seven-segment display package.
// Digit count and the vector types shared by the scan display stages.
//------------------------------
package seg_pkg;

	// Eight digits, one per nibble of the 32-bit display word.
	localparam int digit_count = 8;

	// Width of one hex digit value.
	localparam int nibble_w = 4;

	// Width of one segment pattern (segments a to g plus the decimal point).
	localparam int seg_w = 8;

	// Width of the digit index, enough to count through all digits.
	localparam int digit_idx_w = $clog2(digit_count);

	// One hex digit value.
	typedef logic [nibble_w-1:0] nibble_t;

	// Active-low segment pattern, bit 7 is the decimal point and bits 6..0 are g..a.
	typedef logic [seg_w-1:0] seg_pattern_t;

	// One bit per digit. Used for the enable mask and the active-low select.
	typedef logic [digit_count-1:0] digit_mask_t;

	// Index of the digit being scanned.
	typedef logic [digit_idx_w-1:0] digit_idx_t;

	// Eight nibbles, digit 0 sits in the top nibble.
	typedef logic [digit_count*nibble_w-1:0] display_word_t;

	// Pattern with every segment dark.
	localparam seg_pattern_t seg_blank = '1;

	// Select value with no digit driven.
	localparam digit_mask_t sel_none = '1;

	// Index of the last digit in a frame.
	localparam digit_idx_t last_digit = digit_idx_t'(digit_count - 1);

endpackage

/* tb.f */
seg_pkg.sv
scan_tick_gen.sv
frame_buffer.sv
digit_scanner.sv
seg_encoder.sv
seg_display.sv
seg_checker.sv
tb_seg_display.sv

/* tb_seg_display.sv */
//------------------------------
// Display driver testbench.
// Drives LFSR stimulus into the DUT, one test phase at a time.
//------------------------------
module tb_seg_display
	import seg_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned clk_hz      = 1000;	// Gives a tick divider of 4.
	localparam int unsigned rate_hz     = 250;
	localparam int          wrap_limit  = 100;	// Cycles allowed for one frame wrap.
	localparam int          sim_limit   = 20000;	// Cycles before the run is called hung.
	localparam int          test_total  = 6;

	logic          sys_clk = 1'b0;
	logic          sys_rst_n;
	display_word_t seg_val;
	digit_mask_t   seg_sel;
	logic          val_load;
	seg_pattern_t  seg_val_out;
	digit_mask_t   seg_sel_out;

	int   test_num;			// Phase number shown to the checker.
	logic test_run;			// High while a phase is running.
	logic test_timeout;		// A wait in the running phase gave up.
	logic all_done;			// Last phase finished.
	logic sim_over = 1'b0;		// Verdict printed, stops the watchdog.
	int   chk_pass;
	int   chk_fail;
	int   chk_timeouts;
	logic chk_stall;
	logic report_done;
	logic [31:0] lfsr_state = 32'hefb;	// Seed of the stimulus sequence.

	always #2 sys_clk = ~sys_clk;		// 4 ns period.

	seg_display #(
		.clk_freq_hz   (clk_hz),
		.digit_rate_hz (rate_hz)
	) dut0 (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.seg_val     (seg_val),
		.seg_sel     (seg_sel),
		.val_load    (val_load),
		.seg_val_out (seg_val_out),
		.seg_sel_out (seg_sel_out)
	);

	seg_checker #(
		.clk_freq_hz   (clk_hz),
		.digit_rate_hz (rate_hz)
	) u_seg_checker (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.seg_val       (seg_val),
		.seg_sel       (seg_sel),
		.val_load      (val_load),
		.seg_val_out   (seg_val_out),
		.seg_sel_out   (seg_sel_out),
		.test_num      (test_num),
		.test_run      (test_run),
		.test_timeout  (test_timeout),
		.all_done      (all_done),
		.pass_count    (chk_pass),
		.fail_count    (chk_fail),
		.timeout_count (chk_timeouts),
		.stalled       (chk_stall),
		.report_done   (report_done)
	);

	// Galois step, taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Takes n bits, the LFSR moves once for every bit.
	task automatic random_bits(input int n, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Moves to the drive point just after the next rising edge.
	task automatic next_cycle();
		@(posedge sys_clk);
		#0.5;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// Stops at the drive point in front of a wrap edge.
	task automatic wait_before_wrap();
		int waited;
		waited = 0;
		while (!dut0.frame_wrap && waited < wrap_limit) begin
			next_cycle();
			waited++;
		end
		if (!dut0.frame_wrap) test_timeout = 1'b1;	// Checker reports it at phase end.
	endtask

	// Lets n frame wraps pass.
	task automatic wait_wraps(input int n);
		repeat (n) begin
			wait_before_wrap();
			next_cycle();
		end
	endtask

	task automatic load_display(input display_word_t word, input digit_mask_t mask);
		seg_val  = word;
		seg_sel  = mask;
		val_load = 1'b1;	// Strobe for one edge.
		next_cycle();
		val_load = 1'b0;
	endtask

	task automatic begin_test(input int n);
		test_num     = n;
		test_timeout = 1'b0;
		test_run     = 1'b1;
	endtask

	task automatic finish_test();
		test_run = 1'b0;	// Checker prints the phase line on this drop.
		next_cycle();
	endtask

	initial begin
		logic [31:0] rnd_word;
		logic [31:0] rnd_mask;
		logic [31:0] rnd_gap;
		int          i;
		int          waited;
		sys_rst_n    = 1'b0;
		seg_val      = '0;
		seg_sel      = '0;
		val_load     = 1'b0;
		test_num     = 0;
		test_run     = 1'b0;
		test_timeout = 1'b0;
		all_done     = 1'b0;
		repeat (2) @(posedge sys_clk);
		#0.5;
		sys_rst_n = 1'b1;

		begin_test(0);			// Outputs stay dark with nothing loaded.
		wait_wraps(2);
		finish_test();

		begin_test(1);			// Every hex digit once, in two words.
		load_display(32'h0123_4567, 8'hFF);
		wait_wraps(2);
		load_display(32'h89AB_CDEF, 8'hFF);
		wait_wraps(2);
		finish_test();

		begin_test(2);			// Select walks 0 to 7 with all digits on.
		random_bits(32, rnd_word);
		load_display(rnd_word, 8'hFF);
		wait_wraps(3);
		finish_test();

		begin_test(3);
		for (i = 0; i < 3; i++) begin
			random_bits(32, rnd_word);
			random_bits(8, rnd_mask);
			load_display(rnd_word, rnd_mask[7:0]);
			wait_wraps(2);
		end
		finish_test();

		begin_test(4);
		wait_wraps(1);
		idle_cycles(10);		// Middle of the frame.
		load_display(32'hA5A5_5A5A, 8'hF0);
		idle_cycles(5);
		load_display(32'h1357_9BDF, 8'h3C);	// Last load before the wrap wins.
		wait_before_wrap();
		load_display(32'hFEDC_BA98, 8'hFF);	// Load on the commit edge stays pending.
		wait_wraps(2);
		finish_test();

		begin_test(5);
		for (i = 0; i < 30; i++) begin
			random_bits(32, rnd_word);
			random_bits(8, rnd_mask);
			random_bits(6, rnd_gap);
			load_display(rnd_word, rnd_mask[7:0]);
			idle_cycles(int'(rnd_gap));
		end
		wait_wraps(2);
		finish_test();

		all_done = 1'b1;
		waited   = 0;
		while (!report_done && waited < 10) begin
			next_cycle();
			waited++;
		end
		sim_over = 1'b1;
		if (report_done && chk_fail == 0 && chk_timeouts == 0 && !chk_stall &&
				chk_pass == test_total) begin
			$display("TEST RESULT: PASS");
		end else begin
			if (!report_done) $display("checker did not print its final report");
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Hang guard for the whole run.
	initial begin
		int cycles;
		for (cycles = 0; cycles < sim_limit && !sim_over; cycles++) @(posedge sys_clk);
		if (!sim_over) begin
			$display("simulation ran past %0d cycles without finishing", sim_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule
